// ==== rtl/bridge_pkg.sv ====
/*
 * bridge_pkg
 * Shared widths, SD protocol constants and the SD command frame layout
 * for the DRAM to SD single-block write bridge
 */
package bridge_pkg;

    // ################################################
    // Widths
    // ################################################
    localparam int dram_addr_w     = 13;
    localparam int axi_addr_w      = 32;
    localparam int sd_addr_w       = 16;
    localparam int sd_arg_w        = 32;
    localparam int block_w         = 64;
    localparam int byte_w          = 8;
    localparam int bytes_per_block = 8;

    // ################################################
    // SD protocol
    // ################################################
    // CMD24 is the single block write
    localparam logic [5:0]  cmd_write_block = 6'd24;
    localparam int          cmd_frame_w     = 48;
    // Token, 64 data bits, CRC16
    localparam int          data_frame_w    = 88;
    localparam logic [7:0]  start_token     = 8'hfe;
    // x^7 + x^3 + 1
    localparam logic [6:0]  crc7_poly       = 7'h09;
    // CCITT polynomial x^16 + x^12 + x^5 + 1
    localparam logic [15:0] crc16_poly      = 16'h1021;
    localparam int          resp_gap        = 8;

    // Command frame with its MSB first on the line
    typedef struct packed {
        logic [1:0]          start_bits;
        logic [5:0]          index;
        logic [sd_arg_w-1:0] argument;
        logic [6:0]          crc7;
        logic                end_bit;
    } sd_cmd_fields_t;

    // Same 48 bits as a flat word for shifting
    typedef union packed {
        logic [cmd_frame_w-1:0] raw;
        sd_cmd_fields_t         fields;
    } sd_cmd_frame_u;

endpackage

// ==== rtl/dram_reader.sv ====
/*
 * dram_reader
 * Latches a transfer request, fetches one 64-bit word over the AXI read
 * channel and offers it to the SD side through a valid/ready pair
 */
module dram_reader (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  logic [bridge_pkg::dram_addr_w-1:0] addr_dram,
    input  logic [bridge_pkg::sd_addr_w-1:0]   addr_sd,
    output logic                               ar_valid,
    output logic [bridge_pkg::axi_addr_w-1:0]  ar_addr,
    input  logic                               ar_ready,
    input  logic                               r_valid,
    input  logic [bridge_pkg::block_w-1:0]     r_data,
    output logic                               r_ready,
    output logic                               block_valid,
    input  logic                               block_ready,
    output logic [bridge_pkg::block_w-1:0]     block_data,
    output logic [bridge_pkg::sd_addr_w-1:0]   sd_addr
);
    import bridge_pkg::*;

    logic ar_fire;
    logic r_fire;
    logic block_fire;

    assign ar_fire    = ar_valid & ar_ready;
    assign r_fire     = r_valid & r_ready;
    assign block_fire = block_valid & block_ready;

    // ################################################
    // AXI read
    // ################################################
    // Address held until the slave takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid <= 1'b0;
        end else if (in_valid) begin
            ar_valid <= 1'b1;
        end else if (ar_fire) begin
            ar_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            ar_addr <= {{(axi_addr_w - dram_addr_w){1'b0}}, addr_dram};
            sd_addr <= addr_sd;
        end
    end

    // Ready for one beat after the address is accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_ready <= 1'b0;
        end else if (ar_fire) begin
            r_ready <= 1'b1;
        end else if (r_fire) begin
            r_ready <= 1'b0;
        end
    end

    // ################################################
    // Hand-off to the SD engine
    // ################################################
    always_ff @(posedge clk) begin
        if (r_fire) begin
            block_data <= r_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_valid <= 1'b0;
        end else if (r_fire) begin
            block_valid <= 1'b1;
        end else if (block_fire) begin
            block_valid <= 1'b0;
        end
    end

endmodule

// ==== rtl/sd_frame_builder.sv ====
/*
 * sd_frame_builder
 * Forms the CMD24 frame with its CRC7 and the data packet with its
 * CRC16, both purely combinational from the latched request
 */
module sd_frame_builder (
    input  logic [bridge_pkg::sd_addr_w-1:0]    sd_addr,
    input  logic [bridge_pkg::block_w-1:0]      block_data,
    output bridge_pkg::sd_cmd_frame_u           cmd_frame,
    output logic [bridge_pkg::data_frame_w-1:0] data_frame
);
    import bridge_pkg::*;

    logic [sd_arg_w-1:0] sd_arg;

    // ################################################
    // Bit-serial CRCs, MSB first, zero seed
    // ################################################
    // Covers start bits, index and argument
    function automatic logic [6:0] crc7_calc(input logic [cmd_frame_w-9:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = cmd_frame_w - 9; i >= 0; i--) begin
            fb  = crc[6] ^ bits[i];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ crc7_poly;
            end
        end
        return crc;
    endfunction

    function automatic logic [15:0] crc16_calc(input logic [block_w-1:0] bits);
        logic [15:0] crc;
        logic        fb;
        crc = '0;
        for (int i = block_w - 1; i >= 0; i--) begin
            fb  = crc[15] ^ bits[i];
            crc = {crc[14:0], 1'b0};
            if (fb) begin
                crc = crc ^ crc16_poly;
            end
        end
        return crc;
    endfunction

    // ################################################
    // Frames
    // ################################################
    // Block address goes straight into the argument
    assign sd_arg = {{(sd_arg_w - sd_addr_w){1'b0}}, sd_addr};

    always_comb begin
        cmd_frame.fields.start_bits = 2'b01;
        cmd_frame.fields.index      = cmd_write_block;
        cmd_frame.fields.argument   = sd_arg;
        cmd_frame.fields.crc7       = crc7_calc({2'b01, cmd_write_block, sd_arg});
        cmd_frame.fields.end_bit    = 1'b1;
    end

    assign data_frame = {start_token, block_data, crc16_calc(block_data)};

endmodule

// ==== rtl/sd_write_engine.sv ====
/*
 * sd_write_engine
 * SPI master for one CMD24 block write. Sends the command, waits out the
 * R1 response, sends the data packet and tracks the card busy phase
 */
module sd_write_engine (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                block_valid,
    output logic                                block_ready,
    input  bridge_pkg::sd_cmd_frame_u           cmd_frame,
    input  logic [bridge_pkg::data_frame_w-1:0] data_frame,
    input  logic                                miso,
    output logic                                mosi,
    output logic                                write_done
);
    import bridge_pkg::*;

    localparam logic [2:0] st_idle     = 3'd0;
    localparam logic [2:0] st_command  = 3'd1;
    localparam logic [2:0] st_response = 3'd2;
    localparam logic [2:0] st_gap      = 3'd3;
    localparam logic [2:0] st_data     = 3'd4;
    localparam logic [2:0] st_busy     = 3'd5;

    logic [2:0]              state;
    logic [2:0]              next_state;
    logic [6:0]              cnt;
    logic [data_frame_w-1:0] shift_reg;
    logic                    handoff;
    logic                    shifting;

    assign handoff  = block_valid & block_ready;
    assign shifting = (state == st_command) || (state == st_data);

    // ################################################
    // FSM
    // ################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (handoff) begin
                    next_state = st_command;
                end
            end
            // All 48 bits on the line, then wait for the R1 start bit
            st_command: begin
                if (cnt >= cmd_frame_w && !miso) begin
                    next_state = st_response;
                end
            end
            // Rest of R1
            st_response: begin
                if (cnt == byte_w - 2) begin
                    next_state = st_gap;
                end
            end
            st_gap: begin
                if (cnt == resp_gap - 1) begin
                    next_state = st_data;
                end
            end
            st_data: begin
                if (cnt == data_frame_w - 1) begin
                    next_state = st_busy;
                end
            end
            // Last data bit and the data response are skipped
            st_busy: begin
                if (cnt > resp_gap && miso) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // Per-state counter that saturates while waiting on the card
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (state != next_state) begin
            cnt <= '0;
        end else if (cnt != '1) begin
            cnt <= cnt + 7'd1;
        end
    end

    // ################################################
    // Shift register and SPI output
    // ################################################
    // Command padded with ones so the line idles high after it
    always_ff @(posedge clk) begin
        if (state == st_idle && handoff) begin
            shift_reg <= {cmd_frame.raw, {(data_frame_w - cmd_frame_w){1'b1}}};
        end else if (state == st_gap && next_state == st_data) begin
            shift_reg <= data_frame;
        end else if (shifting) begin
            shift_reg <= {shift_reg[data_frame_w-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mosi <= 1'b1;
        end else if (shifting) begin
            mosi <= shift_reg[data_frame_w-1];
        end else begin
            mosi <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_ready <= 1'b0;
            write_done  <= 1'b0;
        end else begin
            block_ready <= (next_state == st_idle);
            write_done  <= (state == st_busy) && (next_state == st_idle);
        end
    end

endmodule

// ==== rtl/result_streamer.sv ====
/*
 * result_streamer
 * Sends the written word as eight bytes on out_data, MSB first
 */
module result_streamer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             write_done,
    input  logic [bridge_pkg::block_w-1:0]   block_data,
    output logic                             out_valid,
    output logic [bridge_pkg::byte_w-1:0]    out_data
);
    import bridge_pkg::*;

    logic [$clog2(bytes_per_block)-1:0] byte_idx;
    logic [$clog2(bytes_per_block)-1:0] sel_idx;
    logic [byte_w-1:0]                  sel_byte;
    logic                               last_byte;
    logic                               load;

    // Index of the byte now on out_data
    assign last_byte = (byte_idx == bytes_per_block - 1);
    assign sel_idx   = write_done ? '0 : byte_idx + 1'b1;
    assign sel_byte  = block_data[(block_w - 1) - (byte_w * sel_idx) -: byte_w];
    assign load      = write_done | (out_valid & ~last_byte);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            byte_idx  <= '0;
        end else if (load) begin
            out_valid <= 1'b1;
            out_data  <= sel_byte;
            byte_idx  <= sel_idx;
        end else begin
            out_valid <= 1'b0;
            out_data  <= '0;
            byte_idx  <= '0;
        end
    end

endmodule

// ==== rtl/bridge_top.sv ====
/*
 * bridge_top
 * DRAM to SD bridge with an AXI read, an SPI block write and a byte stream out
 */
module bridge_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  logic [bridge_pkg::dram_addr_w-1:0] addr_dram,
    input  logic [bridge_pkg::sd_addr_w-1:0]   addr_sd,
    output logic                               ar_valid,
    output logic [bridge_pkg::axi_addr_w-1:0]  ar_addr,
    input  logic                               ar_ready,
    input  logic                               r_valid,
    input  logic [bridge_pkg::block_w-1:0]     r_data,
    output logic                               r_ready,
    input  logic                               miso,
    output logic                               mosi,
    output logic                               out_valid,
    output logic [bridge_pkg::byte_w-1:0]      out_data
);
    import bridge_pkg::*;

    logic                    block_valid;
    logic                    block_ready;
    logic [block_w-1:0]      block_data;
    logic [sd_addr_w-1:0]    sd_addr;
    sd_cmd_frame_u           cmd_frame;
    logic [data_frame_w-1:0] data_frame;
    logic                    write_done;

    dram_reader dram_reader_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .addr_dram   (addr_dram),
        .addr_sd     (addr_sd),
        .ar_valid    (ar_valid),
        .ar_addr     (ar_addr),
        .ar_ready    (ar_ready),
        .r_valid     (r_valid),
        .r_data      (r_data),
        .r_ready     (r_ready),
        .block_valid (block_valid),
        .block_ready (block_ready),
        .block_data  (block_data),
        .sd_addr     (sd_addr)
    );

    sd_frame_builder sd_frame_builder_i (
        .sd_addr    (sd_addr),
        .block_data (block_data),
        .cmd_frame  (cmd_frame),
        .data_frame (data_frame)
    );

    sd_write_engine sd_write_engine_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_valid (block_valid),
        .block_ready (block_ready),
        .cmd_frame   (cmd_frame),
        .data_frame  (data_frame),
        .miso        (miso),
        .mosi        (mosi),
        .write_done  (write_done)
    );

    result_streamer result_streamer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .write_done (write_done),
        .block_data (block_data),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

// ==== verif/clock_gen.sv ====
/*
 * clock_gen
 * Testbench clock of period 20 and an active-low reset held for 8 cycles
 */
module clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int period       = 20;
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== verif/sd_card_model.sv ====
/*
 * sd_card_model
 * Behavioral SD card in SPI mode for single-block writes. Collects the
 * command and the data packet from MOSI and answers with R1, the data
 * response token and a busy phase on MISO
 */
module sd_card_model (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                mosi,
    output logic                                miso,
    input  logic [2:0]                          resp_delay,
    input  logic [2:0]                          busy_cycles,
    output bridge_pkg::sd_cmd_frame_u           cmd_frame,
    output int                                  cmd_count,
    output logic [bridge_pkg::data_frame_w-1:0] data_frame,
    output int                                  data_count,
    output logic                                busy
);
    import bridge_pkg::*;

    localparam logic [7:0] r1_ready      = 8'h00;
    localparam logic [7:0] data_accepted = 8'h05;

    logic [cmd_frame_w-1:0]    cmd_bits;
    logic [7:0]                window;
    logic [data_frame_w-9:0]   payload;

    // Called on a falling edge, returns on the falling edge after bit 0
    task automatic send_byte(input logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            miso <= value[i];
            @(negedge clk);
        end
    endtask

    initial begin
        miso       = 1'b1;
        cmd_frame  = '0;
        cmd_count  = 0;
        data_frame = '0;
        data_count = 0;
        busy       = 1'b0;
        forever begin
            @(posedge clk);
            // A command starts with the first 0 on an idle line
            if (rst_n && mosi === 1'b0) begin
                cmd_bits = '0;
                for (int i = 0; i < cmd_frame_w; i++) begin
                    if (i > 0) begin
                        @(posedge clk);
                    end
                    cmd_bits = {cmd_bits[cmd_frame_w-2:0], mosi};
                end
                @(negedge clk);
                cmd_frame.raw <= cmd_bits;
                cmd_count     <= cmd_count + 1;
                // Write in progress until busy is released
                busy          <= 1'b1;
                repeat (resp_delay - 3'd1) @(negedge clk);
                send_byte(r1_ready);
                miso <= 1'b1;

                // ################################################
                // Data packet
                // ################################################
                window = 8'hff;
                while (window != start_token) begin
                    @(posedge clk);
                    window = {window[6:0], mosi};
                end
                // 64 data bits and the CRC16
                for (int i = 0; i < data_frame_w - 8; i++) begin
                    @(posedge clk);
                    payload = {payload[data_frame_w-10:0], mosi};
                end
                @(negedge clk);
                data_frame <= {start_token, payload};
                data_count <= data_count + 1;
                send_byte(data_accepted);
                // Card busy while it programs the block
                miso <= 1'b0;
                repeat (busy_cycles) @(negedge clk);
                miso <= 1'b1;
                busy <= 1'b0;
            end
        end
    end

endmodule

// ==== verif/tb_bridge.sv ====
/*
 * tb_bridge
 * Testbench for the DRAM to SD bridge. Models the AXI read slave,
 * checks the SPI frames seen by the card model and the output bytes
 */
module tb_bridge;
    import bridge_pkg::*;

    localparam int          num_tests       = 12;
    localparam int          cycles_per_test = 400;
    localparam int          max_cycles      = num_tests * cycles_per_test + 20;
    localparam logic [15:0] lfsr_seed       = 16'd35;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic [dram_addr_w-1:0]  addr_dram;
    logic [sd_addr_w-1:0]    addr_sd;
    logic                    ar_valid;
    logic [axi_addr_w-1:0]   ar_addr;
    logic                    ar_ready;
    logic                    r_valid;
    logic [block_w-1:0]      r_data;
    logic                    r_ready;
    logic                    miso;
    logic                    mosi;
    logic                    out_valid;
    logic [byte_w-1:0]       out_data;
    logic [2:0]              resp_delay;
    logic [2:0]              busy_cycles;
    sd_cmd_frame_u           card_cmd;
    logic [data_frame_w-1:0] card_data;
    int                      cmd_count;
    int                      data_count;
    logic                    card_busy;

    logic [15:0]             lfsr_state = lfsr_seed;
    int                      errors = 0;
    int                      failed_tests = 0;
    int                      cycles = 0;
    int                      ar_count = 0;
    int                      cmd_checked = 0;
    int                      data_checked = 0;
    int                      byte_idx = 0;
    logic                    burst_done = 1'b0;
    logic                    test_active = 1'b0;
    logic [axi_addr_w-1:0]   exp_addr;
    sd_cmd_frame_u           exp_cmd;
    logic [data_frame_w-1:0] exp_pkt;
    logic [bytes_per_block-1:0][byte_w-1:0] exp_seq;

    clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bridge_top bridge_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .addr_dram (addr_dram),
        .addr_sd   (addr_sd),
        .ar_valid  (ar_valid),
        .ar_addr   (ar_addr),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r_data    (r_data),
        .r_ready   (r_ready),
        .miso      (miso),
        .mosi      (mosi),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    sd_card_model sd_card_model_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .mosi        (mosi),
        .miso        (miso),
        .resp_delay  (resp_delay),
        .busy_cycles (busy_cycles),
        .cmd_frame   (card_cmd),
        .cmd_count   (cmd_count),
        .data_frame  (card_data),
        .data_count  (data_count),
        .busy        (card_busy)
    );

    // ################################################
    // Random source and reference model
    // ################################################
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw(input int nbits, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[62:0], lfsr_state[0]};
        end
    endtask

    // Remainder of msg * x^deg divided by the generator
    function automatic logic [15:0] poly_remainder(input logic [127:0] msg,
            input int msg_len, input logic [16:0] gen, input int deg);
        logic [127:0] rem;
        rem = msg << deg;
        for (int i = msg_len + deg - 1; i >= deg; i--) begin
            if (rem[i]) begin
                rem = rem ^ ({111'b0, gen} << (i - deg));
            end
        end
        return rem[15:0];
    endfunction

    function automatic void expected_results(input logic [sd_addr_w-1:0] sd_a,
            input logic [block_w-1:0] word, output sd_cmd_frame_u cmd,
            output logic [data_frame_w-1:0] pkt,
            output logic [bytes_per_block-1:0][byte_w-1:0] seq);
        logic [15:0]        crc7_full;
        logic [15:0]        crc16;
        logic [block_w-1:0] rest;
        cmd                   = '0;
        cmd.fields.start_bits = 2'b01;
        cmd.fields.index      = 6'd24;
        cmd.fields.argument[sd_addr_w-1:0] = sd_a;
        crc7_full             = poly_remainder({88'b0, cmd.raw[47:8]}, 40, 17'h00089, 7);
        cmd.fields.crc7       = crc7_full[6:0];
        cmd.fields.end_bit    = 1'b1;
        crc16                 = poly_remainder({64'b0, word}, 64, 17'h11021, 16);
        pkt                   = {8'hfe, word, crc16};
        // First byte out is the top of the word
        rest = word;
        for (int k = 0; k < bytes_per_block; k++) begin
            seq[k] = rest[block_w-1 -: byte_w];
            rest   = rest << byte_w;
        end
    endfunction

    // ################################################
    // Compare tasks
    // ################################################
    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input logic [axi_addr_w-1:0] got,
            input logic [axi_addr_w-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: ar_addr %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_cmd(input sd_cmd_frame_u got, input sd_cmd_frame_u exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: command %h, expected %h (index %0d arg %h crc7 %h)",
                     $time, got.raw, exp.raw, got.fields.index, got.fields.argument,
                     got.fields.crc7);
        end
    endtask

    task automatic check_data(input logic [data_frame_w-1:0] got,
            input logic [data_frame_w-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: data packet %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_byte(input logic [byte_w-1:0] got, input logic [byte_w-1:0] exp,
            input int idx);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: out_data byte %0d is %h, expected %h",
                     $time, idx, got, exp);
        end
    endtask

    // ################################################
    // Compare process
    // ################################################
    always @(posedge clk) begin
        if (rst_n) begin
            if (ar_valid && ar_ready) begin
                ar_count++;
            end
            if (cmd_count != cmd_checked) begin
                check_cmd(card_cmd, exp_cmd);
                cmd_checked++;
            end
            if (data_count != data_checked) begin
                check_data(card_data, exp_pkt);
                data_checked++;
            end
            if (out_valid) begin
                if (!test_active || byte_idx == bytes_per_block) begin
                    errors++;
                    $display("At %0t out_valid was high outside a result burst", $time);
                end else begin
                    if (byte_idx == 0 && card_busy) begin
                        errors++;
                        $display("At %0t out_valid rose before the card released busy",
                                 $time);
                    end
                    check_byte(out_data, exp_seq[byte_idx], byte_idx);
                    byte_idx++;
                    burst_done = (byte_idx == bytes_per_block);
                end
            end else if (byte_idx != 0 && byte_idx != bytes_per_block) begin
                errors++;
                $display("At %0t out_valid dropped after %0d bytes", $time, byte_idx);
                byte_idx   = bytes_per_block;
                burst_done = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run was still busy after %0d cycles", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ################################################
    // Stimulus and DRAM model
    // ################################################
    initial begin
        logic [63:0]        rnd;
        logic [block_w-1:0] word;
        logic [1:0]         ar_delay;
        logic [1:0]         r_delay;
        int                 errors_before;
        in_valid    = 1'b0;
        addr_dram   = '0;
        addr_sd     = '0;
        ar_ready    = 1'b0;
        r_valid     = 1'b0;
        r_data      = '0;
        resp_delay  = 3'd1;
        busy_cycles = 3'd1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_level("ar_valid", ar_valid, 1'b0);
        check_level("r_ready", r_ready, 1'b0);
        check_level("out_valid", out_valid, 1'b0);
        check_level("mosi", mosi, 1'b1);
        if (out_data !== '0) begin
            errors++;
            $display("** Error at %0t: out_data %h after reset, expected 0", $time, out_data);
        end
        for (int t = 0; t < num_tests; t++) begin
            errors_before = errors;
            draw(dram_addr_w, rnd);
            addr_dram = rnd[dram_addr_w-1:0];
            draw(sd_addr_w, rnd);
            addr_sd = rnd[sd_addr_w-1:0];
            draw(block_w, rnd);
            word = rnd;
            draw(2, rnd);
            ar_delay = rnd[1:0];
            draw(2, rnd);
            r_delay = rnd[1:0];
            draw(2, rnd);
            resp_delay = rnd[1:0] + 3'd1;
            draw(3, rnd);
            busy_cycles = rnd[2:0] % 6 + 3'd1;
            exp_addr = '0;
            exp_addr[dram_addr_w-1:0] = addr_dram;
            expected_results(addr_sd, word, exp_cmd, exp_pkt, exp_seq);

            in_valid    = 1'b1;
            test_active = 1'b1;
            byte_idx    = 0;
            burst_done  = 1'b0;
            @(negedge clk);
            in_valid = 1'b0;
            // Address must hold steady while ready is late
            repeat (ar_delay) begin
                check_level("ar_valid", ar_valid, 1'b1);
                check_addr(ar_addr, exp_addr);
                @(negedge clk);
            end
            check_level("ar_valid", ar_valid, 1'b1);
            check_addr(ar_addr, exp_addr);
            ar_ready = 1'b1;
            @(negedge clk);
            ar_ready = 1'b0;
            check_level("ar_valid after handshake", ar_valid, 1'b0);
            check_level("r_ready", r_ready, 1'b1);
            repeat (r_delay) @(negedge clk);
            r_valid = 1'b1;
            r_data  = word;
            @(negedge clk);
            r_valid = 1'b0;
            r_data  = '0;
            check_level("r_ready after beat", r_ready, 1'b0);

            while (!burst_done) begin
                @(negedge clk);
            end
            test_active = 1'b0;
            if (ar_count != t + 1 || cmd_checked != t + 1 || data_checked != t + 1) begin
                errors++;
                $display("Test %0d saw %0d AR handshakes, %0d commands, %0d data packets",
                         t, ar_count, cmd_checked, data_checked);
            end
            if (errors == errors_before) begin
                $display("test %0d ok: dram %h sd %h word %h", t, addr_dram, addr_sd, word);
            end else begin
                failed_tests++;
                $display("test %0d failed with %0d errors", t, errors - errors_before);
            end
        end
        // Catch a stray burst after the last test
        repeat (4) @(negedge clk);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, num_tests - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/bridge_pkg.sv
rtl/dram_reader.sv
rtl/sd_frame_builder.sv
rtl/sd_write_engine.sv
rtl/result_streamer.sv
rtl/bridge_top.sv
verif/clock_gen.sv
verif/sd_card_model.sv
verif/tb_bridge.sv
